//--- Bender.yml
package:
  name: branch_predictor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/bp_pkg.sv
      - design/branch_decode.sv
      - design/branch_history_table.sv
      - design/branch_target_buffer.sv
      - design/branch_predictor.sv
      - design/bp_csr.sv
      - design/bp_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/bp_tb.sv

//--- compile.f
+incdir+include
design/bp_pkg.sv
design/branch_decode.sv
design/branch_history_table.sv
design/branch_target_buffer.sv
design/branch_predictor.sv
design/bp_csr.sv
design/bp_top.sv
sim/bp_tb.sv

//--- design/bp_csr.sv
`timescale 1ns/100ps
`default_nettype none

module bp_csr (
  input  wire logic            clock,
  input  wire logic            reset,
  input  wire bp_pkg::wb_req_t wb_req,
  output bp_pkg::wb_rsp_t      wb_rsp,
  output logic                 predict_en,
  output logic                 flush,
  input  wire logic [1:0]      taken_event,
  input  wire logic            rollback_event
);
  import bp_pkg::*;

  logic     ack;
  logic     req;
  logic     wr;
  wb_data_t rd_data;
  wb_data_t dat_r;
  wb_data_t taken_count;
  wb_data_t rollback_count;

  // master keeps stb up during the ack cycle, so mask it there
  assign req = wb_req.cyc && wb_req.stb && !ack;
  assign wr  = req && wb_req.we;

  always_comb begin
    case (wb_req.adr)
      ctrl_offset:           rd_data = {30'b0, 1'b0, predict_en}; // flush reads 0
      taken_count_offset:    rd_data = taken_count;
      rollback_count_offset: rd_data = rollback_count;
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ack        <= 1'b0;
      predict_en <= 1'b1;
      flush      <= 1'b0;
    end else begin
      ack   <= req;
      flush <= wr && (wb_req.adr == ctrl_offset) && wb_req.dat_w[1]; // one cycle
      if (wr && (wb_req.adr == ctrl_offset)) begin
        predict_en <= wb_req.dat_w[0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req) begin
      dat_r <= rd_data;
    end
  end

  // event counters, any write clears
  always_ff @(posedge clock) begin
    if (reset) begin
      taken_count    <= '0;
      rollback_count <= '0;
    end else begin
      if (wr && (wb_req.adr == taken_count_offset)) begin
        taken_count <= '0;
      end else begin
        taken_count <= taken_count + wb_data_t'(taken_event);
      end
      if (wr && (wb_req.adr == rollback_count_offset)) begin
        rollback_count <= '0;
      end else begin
        rollback_count <= rollback_count + wb_data_t'(rollback_event);
      end
    end
  end

  always_comb begin
    wb_rsp.ack   = ack;
    wb_rsp.dat_r = dat_r;
  end

  single_cycle_ack: assert property (@(posedge clock) disable iff (reset)
    ack |=> !ack)
    else $error("wishbone ack held for more than one cycle");

endmodule

`default_nettype wire

//--- design/bp_pkg.sv
`default_nettype none

package bp_pkg;

  localparam int num_super = 2; // slot selection is written for two slots

  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [1:0]  counter_t;
  typedef logic [3:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  localparam counter_t counter_reset = 2'b01; // weakly not-taken
  localparam addr_t    btb_reset     = '0;

  // register map
  localparam wb_addr_t ctrl_offset           = 4'h0;
  localparam wb_addr_t taken_count_offset    = 4'h4;
  localparam wb_addr_t rollback_count_offset = 4'h8;

  typedef struct packed {
    logic  [num_super-1:0] inst_valid;
    addr_t [num_super-1:0] npc;
    inst_t [num_super-1:0] inst;
  } fetch_bundle_t;

  typedef struct packed {
    logic  [num_super-1:0] is_branch;
    logic  [num_super-1:0] taken;
    addr_t [num_super-1:0] pc;
    addr_t [num_super-1:0] target;
    logic                  sel; // slot behind the rollback
  } resolve_t;

  typedef struct packed {
    logic  [num_super-1:0] inst_valid;
    logic  [num_super-1:0] take_branch;
    addr_t                 target;
  } prediction_t;

  typedef struct packed {
    logic [num_super-1:0] is_cond;
    logic [num_super-1:0] is_uncond;
  } branch_class_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- design/bp_top.sv
`timescale 1ns/100ps
`default_nettype none

module bp_top #(
  parameter int bh_idx_bits = 4
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire bp_pkg::fetch_bundle_t fetch,
  input  wire logic                  rollback_en,
  input  wire bp_pkg::resolve_t      resolve,
  input  wire bp_pkg::wb_req_t       wb_req,
  output bp_pkg::wb_rsp_t            wb_rsp,
  output bp_pkg::prediction_t        prediction
);

  logic       predict_en;
  logic       flush;
  logic [1:0] taken_event;
  logic       rollback_event;

  branch_predictor #(.bh_idx_bits(bh_idx_bits)) u_branch_predictor (
    .clock          (clock),
    .reset          (reset),
    .fetch          (fetch),
    .rollback_en    (rollback_en),
    .resolve        (resolve),
    .predict_en     (predict_en),
    .flush          (flush),
    .prediction     (prediction),
    .taken_event    (taken_event),
    .rollback_event (rollback_event)
  );

  bp_csr u_bp_csr (
    .clock          (clock),
    .reset          (reset),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .predict_en     (predict_en),
    .flush          (flush),
    .taken_event    (taken_event),
    .rollback_event (rollback_event)
  );

endmodule

`default_nettype wire

//--- design/branch_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_opcodes.svh"

module branch_decode (
  input  wire bp_pkg::fetch_bundle_t fetch,
  input  wire logic                  rollback_en,
  output bp_pkg::branch_class_t      classes
);
  import bp_pkg::*;

  opcode_t [num_super-1:0] opcode;

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      opcode[i] = fetch.inst[i][31:26];
    end
  end

  // slots behind a rollback are squashed, so nothing counts as a branch
  always_comb begin
    classes = '0;
    for (int i = 0; i < num_super; i++) begin
      if (fetch.inst_valid[i] && !rollback_en) begin
        case (opcode[i])
          `BLBC_INST, `BEQ_INST, `BLT_INST, `BLE_INST,
          `BLBS_INST, `BNE_INST, `BGE_INST, `BGT_INST: begin
            classes.is_cond[i] = 1'b1;
          end
          default: begin
          end
        endcase
        // each group is matched on its own
        case (opcode[i])
          `BR_INST, `BSR_INST, `JSR_GRP: begin
            classes.is_uncond[i] = 1'b1; // always redirects
          end
          default: begin
          end
        endcase
      end
    end
  end

  // opcode groups in the macro file must not overlap
  no_dual_class: assert #0 ((classes.is_cond & classes.is_uncond) == '0)
    else $error("slot decoded as both conditional and unconditional");

endmodule

`default_nettype wire

//--- design/branch_history_table.sv
`timescale 1ns/100ps
`default_nettype none

module branch_history_table #(
  parameter int bh_idx_bits = 4
) (
  input  wire logic                                  clock,
  input  wire logic                                  reset,
  input  wire logic                                  flush,
  input  wire bp_pkg::resolve_t                      resolve,
  input  wire bp_pkg::addr_t [bp_pkg::num_super-1:0] rd_pc,
  output logic [bp_pkg::num_super-1:0]               rd_taken
);
  import bp_pkg::*;

  localparam int entries = 2 ** bh_idx_bits;

  counter_t [entries-1:0] bht;
  counter_t [entries-1:0] next_bht;

  logic [num_super-1:0][bh_idx_bits-1:0] wr_idx; // from resolved branch pc
  logic [num_super-1:0][bh_idx_bits-1:0] rd_idx; // from fetch next-pc

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      wr_idx[i] = resolve.pc[i][bh_idx_bits+1:2];
      rd_idx[i] = rd_pc[i][bh_idx_bits+1:2];
    end
  end

  // training goes slot by slot, so two resolves on one entry both count
  always_comb begin
    next_bht = bht;
    for (int i = 0; i < num_super; i++) begin
      if (resolve.is_branch[i]) begin
        if (resolve.taken[i]) begin
          if (next_bht[wr_idx[i]] != 2'b11) begin
            next_bht[wr_idx[i]] = next_bht[wr_idx[i]] + 2'b01;
          end
        end else begin
          if (next_bht[wr_idx[i]] != 2'b00) begin
            next_bht[wr_idx[i]] = next_bht[wr_idx[i]] - 2'b01;
          end
        end
      end
    end
  end

  // reads see this cycle's training
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      rd_taken[i] = next_bht[rd_idx[i]][1];
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      bht <= {entries{counter_reset}};
    end else begin
      bht <= next_bht;
    end
  end

  // flush comes from a register block that is itself held in reset
  flush_outside_reset: assert property (@(posedge clock) !(flush && reset))
    else $error("flush asserted during reset");

endmodule

`default_nettype wire

//--- design/branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor #(
  parameter int bh_idx_bits = 4
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire bp_pkg::fetch_bundle_t fetch,
  input  wire logic                  rollback_en,
  input  wire bp_pkg::resolve_t      resolve,
  input  wire logic                  predict_en,
  input  wire logic                  flush,
  output bp_pkg::prediction_t        prediction,
  output logic [1:0]                 taken_event,
  output logic                       rollback_event
);
  import bp_pkg::*;

  branch_class_t           classes;
  logic  [num_super-1:0]   counter_taken;
  addr_t [num_super-1:0]   btb_target;
  logic  [num_super-1:0]   take;
  logic  [num_super-1:0]   valid;
  logic                    btb_wr_en;

  branch_decode u_branch_decode (
    .fetch       (fetch),
    .rollback_en (rollback_en),
    .classes     (classes)
  );

  branch_history_table #(.bh_idx_bits(bh_idx_bits)) u_branch_history_table (
    .clock    (clock),
    .reset    (reset),
    .flush    (flush),
    .resolve  (resolve),
    .rd_pc    (fetch.npc),
    .rd_taken (counter_taken)
  );

  // only taken rollbacks teach the buffer a target
  assign btb_wr_en = rollback_en && resolve.taken[resolve.sel];

  branch_target_buffer #(.bh_idx_bits(bh_idx_bits)) u_branch_target_buffer (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .wr_en     (btb_wr_en),
    .wr_pc     (resolve.pc[resolve.sel]),
    .wr_target (resolve.target[resolve.sel]),
    .rd_pc     (fetch.npc),
    .rd_target (btb_target)
  );

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      take[i] = classes.is_uncond[i] ||
                (classes.is_cond[i] && predict_en && counter_taken[i]) ||
                rollback_en;
    end
    valid[0] = fetch.inst_valid[0] && !rollback_en;
    valid[1] = fetch.inst_valid[1] && !rollback_en && !take[0]; // squashed behind a taken slot 0
  end

  always_comb begin
    prediction.inst_valid  = valid;
    prediction.take_branch = take;
    if (rollback_en) begin
      prediction.target = resolve.target[resolve.sel];
    end else if (take[0]) begin
      prediction.target = btb_target[0];
    end else if (take[1]) begin
      prediction.target = btb_target[1];
    end else begin
      prediction.target = fetch.npc[1]; // fall through
    end
  end

  // events for the register block counters
  assign taken_event    = 2'(take[0] && valid[0]) + 2'(take[1] && valid[1]);
  assign rollback_event = rollback_en;

  // fetch relies on slot 1 being dropped after a redirect in slot 0
  slot1_after_taken: assert property (@(posedge clock) disable iff (reset)
    prediction.take_branch[0] |-> !prediction.inst_valid[1])
    else $error("slot 1 valid while slot 0 redirects fetch");

endmodule

`default_nettype wire

//--- design/branch_target_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer #(
  parameter int bh_idx_bits = 4
) (
  input  wire logic                                  clock,
  input  wire logic                                  reset,
  input  wire logic                                  flush,
  input  wire logic                                  wr_en,
  input  wire bp_pkg::addr_t                         wr_pc,
  input  wire bp_pkg::addr_t                         wr_target,
  input  wire bp_pkg::addr_t [bp_pkg::num_super-1:0] rd_pc,
  output bp_pkg::addr_t [bp_pkg::num_super-1:0]      rd_target
);
  import bp_pkg::*;

  localparam int entries = 2 ** bh_idx_bits;

  addr_t [entries-1:0] btb;
  addr_t [entries-1:0] next_btb;

  logic [bh_idx_bits-1:0] wr_idx;
  logic [num_super-1:0][bh_idx_bits-1:0] rd_idx;

  assign wr_idx = wr_pc[bh_idx_bits+1:2];

  always_comb begin
    next_btb = btb;
    if (wr_en) begin
      next_btb[wr_idx] = wr_target; // single write port, no tag
    end
  end

  // lookups forward the write made this cycle
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      rd_idx[i]    = rd_pc[i][bh_idx_bits+1:2];
      rd_target[i] = next_btb[rd_idx[i]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      btb <= {entries{btb_reset}};
    end else begin
      btb <= next_btb;
    end
  end

endmodule

`default_nettype wire

//--- include/bp_opcodes.svh
`ifndef BP_OPCODES_SVH
`define BP_OPCODES_SVH

// major opcodes, instruction bits 31:26

// conditional branches
`define BLBC_INST 6'h38
`define BEQ_INST  6'h39
`define BLT_INST  6'h3a
`define BLE_INST  6'h3b
`define BLBS_INST 6'h3c
`define BNE_INST  6'h3d
`define BGE_INST  6'h3e
`define BGT_INST  6'h3f

// unconditional branches
`define BR_INST   6'h30
`define BSR_INST  6'h34
`define JSR_GRP   6'h1a // jmp, jsr, ret, jsr_coroutine

`endif

//--- sim/bp_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_opcodes.svh"

module bp_tb;
  import bp_pkg::*;

  localparam int      clock_period = 40;
  localparam int      reset_cycles = 10;
  localparam int      num_wb_ops   = 14; // register accesses in test 5
  localparam int      ack_limit    = 8;
  localparam opcode_t op_nop       = 6'h10; // integer operate group
  localparam addr_t   learned_tgt  = 64'h0000_0000_8000_1230;

  typedef struct packed {
    fetch_bundle_t fetch;
    logic          rollback_en;
    resolve_t      resolve;
    prediction_t   expected;
  } row_t;

  logic          clock;
  logic          reset;
  fetch_bundle_t fetch;
  logic          rollback_en;
  resolve_t      resolve;
  wb_req_t       wb_req;
  wb_rsp_t       wb_rsp;
  prediction_t   prediction;

  row_t rows[$];
  int   bounds[$]; // first row of each segment, plus the end
  bit   table_built;
  int   checks;
  int   errors;
  int   exp_taken;    // predicted-taken slots since last clear
  int   exp_rollback;

  bp_top #(.bh_idx_bits(4)) u_bp_top (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .rollback_en (rollback_en),
    .resolve     (resolve),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .prediction  (prediction)
  );

  always #(clock_period / 2) clock = ~clock;

  function automatic inst_t make_inst(opcode_t op);
    return {op, 26'($urandom)}; // random operand fields
  endfunction

  function automatic fetch_bundle_t make_fetch(logic [1:0] valid, addr_t npc0, inst_t inst0,
                                               addr_t npc1, inst_t inst1);
    fetch_bundle_t f;
    f.inst_valid = valid;
    f.npc[0]     = npc0;
    f.npc[1]     = npc1;
    f.inst[0]    = inst0;
    f.inst[1]    = inst1;
    return f;
  endfunction

  // lookups use the slot's next-pc, so a resolve reports that same value
  function automatic resolve_t resolve_one(logic slot, logic taken, addr_t pc, addr_t target);
    resolve_t r;
    r                 = '0;
    r.is_branch[slot] = 1'b1;
    r.taken[slot]     = taken;
    r.pc[slot]        = pc;
    r.target[slot]    = target;
    r.sel             = slot;
    return r;
  endfunction

  function automatic prediction_t expect_pred(logic [1:0] valid, logic [1:0] take,
                                              addr_t target);
    prediction_t p;
    p.inst_valid  = valid;
    p.take_branch = take;
    p.target      = target;
    return p;
  endfunction

  function automatic void add_row(fetch_bundle_t f, logic rb, resolve_t r, prediction_t e);
    row_t row;
    row.fetch       = f;
    row.rollback_en = rb;
    row.resolve     = r;
    row.expected    = e;
    rows.push_back(row);
  endfunction

  task automatic build_table();
    fetch_bundle_t cond_pair;
    fetch_bundle_t br_learned;
    fetch_bundle_t br_fresh;
    fetch_bundle_t nop_pair;
    bounds.push_back(0);
    // test 1, no branches
    add_row(make_fetch(2'b11, 64'h1004, make_inst(op_nop), 64'h1008, make_inst(op_nop)),
            1'b0, '0, expect_pred(2'b11, 2'b00, 64'h1008));
    add_row(make_fetch(2'b11, 64'h1104, make_inst(op_nop), 64'h1108, make_inst(op_nop)),
            1'b0, '0, expect_pred(2'b11, 2'b00, 64'h1108));
    add_row(make_fetch(2'b10, 64'h1204, make_inst(`BR_INST), 64'h1208, make_inst(op_nop)),
            1'b0, '0, expect_pred(2'b10, 2'b00, 64'h1208)); // invalid branch ignored
    bounds.push_back(rows.size());
    // test 2, unconditional branches against an empty target buffer
    add_row(make_fetch(2'b11, 64'h2004, make_inst(`BR_INST), 64'h2008, make_inst(op_nop)),
            1'b0, '0, expect_pred(2'b01, 2'b01, 64'h0));
    add_row(make_fetch(2'b11, 64'h2104, make_inst(op_nop), 64'h2108, make_inst(`BSR_INST)),
            1'b0, '0, expect_pred(2'b11, 2'b10, 64'h0));
    add_row(make_fetch(2'b01, 64'h2008, make_inst(`JSR_GRP), 64'h200c, make_inst(op_nop)),
            1'b0, '0, expect_pred(2'b01, 2'b01, 64'h0));
    bounds.push_back(rows.size());
    // test 3, counter at index 4 walks 01 10 11 10 01 00 00 01 10
    cond_pair = make_fetch(2'b11, 64'h3010, make_inst(`BEQ_INST), 64'h3014, make_inst(op_nop));
    add_row(cond_pair, 1'b0, '0, expect_pred(2'b11, 2'b00, 64'h3014));
    add_row(cond_pair, 1'b0, resolve_one(1'b0, 1'b1, 64'h3010, 64'h3100),
            expect_pred(2'b01, 2'b01, 64'h0));
    add_row(cond_pair, 1'b0, resolve_one(1'b0, 1'b1, 64'h3010, 64'h3100),
            expect_pred(2'b01, 2'b01, 64'h0));
    add_row(cond_pair, 1'b0, resolve_one(1'b0, 1'b0, 64'h3010, 64'h3014),
            expect_pred(2'b01, 2'b01, 64'h0));
    for (int n = 0; n < 3; n++) begin
      add_row(cond_pair, 1'b0, resolve_one(1'b0, 1'b0, 64'h3010, 64'h3014),
              expect_pred(2'b11, 2'b00, 64'h3014));
    end
    add_row(cond_pair, 1'b0, resolve_one(1'b0, 1'b1, 64'h3010, 64'h3100),
            expect_pred(2'b11, 2'b00, 64'h3014)); // saturated at 00, one step is not enough
    add_row(cond_pair, 1'b0, resolve_one(1'b0, 1'b1, 64'h3010, 64'h3100),
            expect_pred(2'b01, 2'b01, 64'h0));
    bounds.push_back(rows.size());
    // test 4, rollbacks
    nop_pair = make_fetch(2'b11, 64'h4004, make_inst(op_nop), 64'h4008, make_inst(op_nop));
    add_row(nop_pair, 1'b1, resolve_one(1'b1, 1'b1, 64'h4020, learned_tgt),
            expect_pred(2'b00, 2'b11, learned_tgt));
    add_row(nop_pair, 1'b1, resolve_one(1'b0, 1'b0, 64'h4030, 64'h4034),
            expect_pred(2'b00, 2'b11, 64'h4034)); // not taken, no buffer write
    br_learned = make_fetch(2'b11, 64'h4020, make_inst(`BR_INST), 64'h4024, make_inst(op_nop));
    br_fresh   = make_fetch(2'b11, 64'h4030, make_inst(`BR_INST), 64'h4034, make_inst(op_nop));
    add_row(br_learned, 1'b0, '0, expect_pred(2'b01, 2'b01, learned_tgt));
    add_row(br_fresh, 1'b0, '0, expect_pred(2'b01, 2'b01, 64'h0));
    bounds.push_back(rows.size());
    // test 5, prediction disabled, re-enabled, then after a flush
    add_row(cond_pair, 1'b0, '0, expect_pred(2'b11, 2'b00, 64'h3014));
    bounds.push_back(rows.size());
    add_row(cond_pair, 1'b0, '0, expect_pred(2'b01, 2'b01, 64'h0));
    add_row(br_learned, 1'b0, '0, expect_pred(2'b01, 2'b01, learned_tgt));
    bounds.push_back(rows.size());
    add_row(cond_pair, 1'b0, '0, expect_pred(2'b11, 2'b00, 64'h3014));
    add_row(br_learned, 1'b0, '0, expect_pred(2'b01, 2'b01, 64'h0));
    bounds.push_back(rows.size());
  endtask

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", what, actual, expected);
    end
  endtask

  task automatic drive_idle();
    fetch       = '0;
    rollback_en = 1'b0;
    resolve     = '0;
  endtask

  task automatic apply_row(input int i);
    row_t r;
    r = rows[i];
    @(negedge clock);
    fetch       = r.fetch;
    rollback_en = r.rollback_en;
    resolve     = r.resolve;
    #(clock_period / 2 - 1); // just before the rising edge
    check_value($sformatf("row %0d prediction.inst_valid", i),
                prediction.inst_valid, r.expected.inst_valid);
    check_value($sformatf("row %0d prediction.take_branch", i),
                prediction.take_branch, r.expected.take_branch);
    check_value($sformatf("row %0d prediction.target", i),
                prediction.target, r.expected.target);
    for (int s = 0; s < num_super; s++) begin
      exp_taken += int'(r.expected.inst_valid[s] && r.expected.take_branch[s]);
    end
    exp_rollback += int'(r.rollback_en);
  endtask

  task automatic run_segment(input int k);
    for (int i = bounds[k]; i < bounds[k+1]; i++) begin
      apply_row(i);
    end
    @(negedge clock);
    drive_idle(); // quiet inputs while the bus is used
  endtask

  task automatic finish_access(input wb_addr_t adr, output wb_data_t data);
    bit acked;
    acked = 1'b0;
    for (int n = 0; n < ack_limit && !acked; n++) begin
      @(negedge clock);
      acked = wb_rsp.ack;
    end
    data       = wb_rsp.dat_r;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    if (!acked) begin
      errors++;
      $display("wishbone access to offset 0x%0h was never acknowledged", adr);
    end
  endtask

  task automatic write_reg(input wb_addr_t adr, input wb_data_t data);
    wb_data_t ignored;
    @(negedge clock);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = 1'b1;
    wb_req.adr   = adr;
    wb_req.dat_w = data;
    finish_access(adr, ignored);
  endtask

  task automatic expect_reg(input wb_addr_t adr, input wb_data_t expected, input string what);
    wb_data_t data;
    @(negedge clock);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = 1'b0;
    wb_req.adr   = adr;
    wb_req.dat_w = '0;
    finish_access(adr, data);
    check_value(what, data, expected);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%-28s ok", name);
    end else begin
      $display("%-28s FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  // watchdog
  initial begin
    wait (table_built);
    #((rows.size() + num_wb_ops + reset_cycles) * 4 * clock_period);
    $display("watchdog expired before the tests completed");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int mark;
    clock        = 1'b0;
    reset        = 1'b1;
    wb_req       = '0;
    checks       = 0;
    errors       = 0;
    exp_taken    = 0;
    exp_rollback = 0;
    drive_idle();
    void'($urandom(32'h364b_25af));
    build_table();
    table_built = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    mark = errors;
    run_segment(0);
    report_test("1 non-branch pair", mark);
    mark = errors;
    run_segment(1);
    report_test("2 unconditional after reset", mark);
    mark = errors;
    run_segment(2);
    report_test("3 counter training", mark);
    mark = errors;
    run_segment(3);
    report_test("4 rollback", mark);

    mark = errors;
    expect_reg(ctrl_offset, 32'h1, "ctrl after reset");
    expect_reg(taken_count_offset, exp_taken, "taken_count");
    expect_reg(rollback_count_offset, exp_rollback, "rollback_count");
    write_reg(ctrl_offset, 32'h0);
    expect_reg(ctrl_offset, 32'h0, "ctrl predict_en off");
    run_segment(4);
    write_reg(ctrl_offset, 32'h1);
    run_segment(5);
    write_reg(ctrl_offset, 32'h3); // keep enabled and flush tables
    expect_reg(ctrl_offset, 32'h1, "ctrl after flush");
    run_segment(6);
    expect_reg(taken_count_offset, exp_taken, "taken_count");
    expect_reg(rollback_count_offset, exp_rollback, "rollback_count");
    write_reg(taken_count_offset, 32'h0);
    exp_taken = 0;
    expect_reg(taken_count_offset, exp_taken, "taken_count cleared");
    write_reg(rollback_count_offset, 32'h0);
    exp_rollback = 0;
    expect_reg(rollback_count_offset, exp_rollback, "rollback_count cleared");
    report_test("5 register block", mark);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
